// ==== verilog/trs_io_pkg.sv ====
package trs_io_pkg;

  // basic widths
  typedef logic [7:0]  byte_t;   // one bus or spi byte
  typedef logic [15:0] addr_t;   // cpu address
  typedef logic [23:0] rgb_t;    // red, green, blue

  // command codes kept from the esp protocol
  typedef enum logic [7:0] {
    get_cookie          = 8'd0,
    set_breakpoint      = 8'd6,
    clear_breakpoint    = 8'd7,
    enable_breakpoints  = 8'd11,
    disable_breakpoints = 8'd12,
    xray_resume         = 8'd13,
    set_full_addr       = 8'd14,
    get_version         = 8'd15,
    set_screen_color    = 8'd17,
    send_keyb           = 8'd19
  } opcode_t;

  localparam int MAX_PARAMS = 3;  // longest parameter list

  // one parsed command, params[0] is the first byte after the opcode
  typedef struct packed {
    opcode_t                    opcode;
    byte_t [MAX_PARAMS-1:0]     params;
  } cmd_frame_t;

  localparam byte_t COOKIE = 8'haf;  // identification reply

  // major in [7:5], minor in [4:0]
  localparam byte_t VERSION_BYTE = {3'd0, 5'd3};

  // parameter bytes that follow each opcode
  function automatic logic [1:0] cmd_param_count(opcode_t op);
    case (op)
      set_breakpoint,
      set_screen_color: cmd_param_count = 2'd3;
      send_keyb:        cmd_param_count = 2'd2;
      clear_breakpoint,
      set_full_addr:    cmd_param_count = 2'd1;
      default:          cmd_param_count = 2'd0;
    endcase
  endfunction

endpackage

// ==== verilog/spi_byte_link.sv ====
`timescale 1ns/100ps

module spi_byte_link (
  input  logic              clk,
  input  logic              rst,
  input  logic              sck,
  input  logic              cs_n,
  input  logic              mosi,
  output logic              miso,
  output logic              rx_valid,
  output trs_io_pkg::byte_t rx_byte,
  input  logic              tx_valid,
  input  trs_io_pkg::byte_t tx_byte,
  output logic              tx_ready
);
  import trs_io_pkg::*;

  logic [2:0] sck_sync;   // [1] synchronized, [2] one cycle older
  logic [2:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic       cs_fall;
  logic       load_tx;
  logic [2:0] bit_cnt;    // bits seen in current byte
  byte_t      rx_shift;
  byte_t      tx_shift;

  // two-flop synchronizers plus one stage for edge detect
  always_ff @(posedge clk) begin
    if (rst) begin
      sck_sync  <= 3'b000;
      cs_sync   <= 3'b111;  // deselected
      mosi_sync <= 2'b00;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[1:0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sck_rise  = (sck_sync[2:1] == 2'b01);
  assign sck_fall  = (sck_sync[2:1] == 2'b10);
  assign cs_active = ~cs_sync[1];
  assign cs_fall   = (cs_sync[2:1] == 2'b10);

  // fetch next reply at select and after every 8th bit
  assign load_tx  = cs_fall || (cs_active && sck_fall && bit_cnt == 3'd0);
  assign tx_ready = load_tx;

  // receive side, mode 0 so sample on rising sck
  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt  <= 3'd0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= cs_active && sck_rise && (bit_cnt == 3'd7);
      if (!cs_active)
        bit_cnt <= 3'd0;           // realign on every select
      else if (sck_rise)
        bit_cnt <= bit_cnt + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      rx_shift <= {rx_shift[6:0], mosi_sync[1]};  // msb first
  end

  assign rx_byte = rx_shift;  // stable for a few cycles after rx_valid

  // transmit side, shift on falling sck
  always_ff @(posedge clk) begin
    if (load_tx)
      tx_shift <= tx_valid ? tx_byte : 8'h00;  // nothing queued, send zero
    else if (cs_active && sck_fall)
      tx_shift <= {tx_shift[6:0], 1'b0};
  end

  assign miso = cs_n ? 1'b0 : tx_shift[7];

  // one byte strobe per byte, never stretched
  rx_valid_single: assert property (@(posedge clk) disable iff (rst)
    rx_valid |=> !rx_valid);

endmodule

// ==== verilog/cmd_framer.sv ====
`timescale 1ns/100ps

module cmd_framer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   rx_valid,
  input  trs_io_pkg::byte_t      rx_byte,
  output logic                   cmd_valid,
  output trs_io_pkg::cmd_frame_t cmd_frame,
  input  logic                   cmd_ready
);
  import trs_io_pkg::*;

  typedef enum logic {idle, read_params} state_t;

  state_t                 state;
  logic [1:0]             remaining;    // param bytes still expected
  logic [1:0]             idx;          // next param slot
  opcode_t                op_q;
  byte_t [MAX_PARAMS-1:0] params_q;
  byte_t [MAX_PARAMS-1:0] next_params;
  opcode_t                rx_op;
  logic [1:0]             rx_count;
  logic                   frame_done;
  cmd_frame_t             next_frame;

  // unknown codes are dropped before they open a frame
  function automatic logic is_kept(byte_t b);
    case (b)
      get_cookie, set_breakpoint, clear_breakpoint, enable_breakpoints,
      disable_breakpoints, xray_resume, set_full_addr, get_version,
      set_screen_color, send_keyb: is_kept = 1'b1;
      default:                     is_kept = 1'b0;
    endcase
  endfunction

  assign rx_op    = opcode_t'(rx_byte);
  assign rx_count = cmd_param_count(rx_op);

  always_comb begin
    next_params      = params_q;
    next_params[idx] = rx_byte;   // merge the byte in flight
    next_frame.opcode = (state == idle) ? rx_op : op_q;
    next_frame.params = (state == idle) ? '0 : next_params;
    frame_done = rx_valid &&
                 ((state == idle && is_kept(rx_byte) && rx_count == 2'd0) ||
                  (state == read_params && remaining == 2'd1));
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= idle;
      remaining <= 2'd0;
      idx       <= 2'd0;
      cmd_valid <= 1'b0;
    end else begin
      if (cmd_valid && cmd_ready)
        cmd_valid <= 1'b0;
      if (frame_done)
        cmd_valid <= 1'b1;      // frame held until the queue takes it
      if (rx_valid) begin
        case (state)
          idle: if (is_kept(rx_byte) && rx_count != 2'd0) begin
            remaining <= rx_count;
            idx       <= 2'd0;
            state     <= read_params;
          end
          read_params: begin
            idx       <= idx + 2'd1;
            remaining <= remaining - 2'd1;
            if (remaining == 2'd1)
              state <= idle;     // last param byte
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // payload side
  always_ff @(posedge clk) begin
    if (rx_valid && state == idle)
      op_q <= rx_op;
    if (rx_valid && state == read_params)
      params_q <= next_params;
    if (frame_done)
      cmd_frame <= next_frame;
  end

  // spi cannot stall, a held frame must drain before the next one completes
  no_frame_overwrite: assert property (@(posedge clk) disable iff (rst)
    frame_done |-> !(cmd_valid && !cmd_ready));

endmodule

// ==== verilog/frame_queue.sv ====
`timescale 1ns/100ps

module frame_queue #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;   // entries held
  logic             push;
  logic             pop;

  assign in_ready  = (count != (PTR_W+1)'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];   // head entry
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;  // any depth
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  count_in_range: assert property (@(posedge clk) disable iff (rst)
    count <= DEPTH);

  // producer keeps its offer until the push
  in_held: assert property (@(posedge clk) disable iff (rst)
    (in_valid && !in_ready) |=> in_valid && $stable(in_data));

endmodule

// ==== verilog/cmd_executor.sv ====
`timescale 1ns/100ps

module cmd_executor #(
  parameter int NUM_BP = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      exe_valid,
  input  trs_io_pkg::cmd_frame_t    exe_frame,
  output logic                      exe_ready,
  output logic                      rep_valid,
  output trs_io_pkg::byte_t         rep_byte,
  input  logic                      rep_ready,
  output logic                      bp_set,
  output logic                      bp_clear,
  output logic                      bp_resume,
  output logic [$clog2(NUM_BP)-1:0] bp_slot,
  output trs_io_pkg::addr_t         bp_addr,
  output logic                      bp_arm,
  output logic                      key_pressed,
  output logic                      reset_req,
  output trs_io_pkg::rgb_t          screen_rgb,
  output logic                      full_addr
);
  import trs_io_pkg::*;

  localparam int SLOT_W = $clog2(NUM_BP);

  logic                   accept;
  opcode_t                op;
  byte_t [MAX_PARAMS-1:0] p;
  byte_t                  keyb [8];   // keyboard matrix, one byte per row
  logic                   any_key;

  assign op = exe_frame.opcode;
  assign p  = exe_frame.params;

  // stall the queue while the reply side is full
  assign exe_ready = rep_ready;
  assign accept    = exe_valid && exe_ready;

  // replies go out in the accept cycle
  assign rep_valid = accept && (op == get_cookie || op == get_version);
  assign rep_byte  = (op == get_version) ? VERSION_BYTE : COOKIE;

  // breakpoint table strobes
  assign bp_set    = accept && (op == set_breakpoint);
  assign bp_clear  = accept && (op == clear_breakpoint);
  assign bp_resume = accept && (op == xray_resume);
  assign bp_slot   = p[0][SLOT_W-1:0];
  assign bp_addr   = {p[2], p[1]};      // high byte last

  always_ff @(posedge clk) begin
    if (rst) begin
      keyb       <= '{default: 8'h00};
      screen_rgb <= '1;                  // white
      full_addr  <= 1'b0;
      bp_arm     <= 1'b0;
    end else if (accept) begin
      case (op)
        send_keyb:           keyb[p[0][2:0]] <= p[1];
        set_screen_color:    screen_rgb <= {p[0], p[1], p[2]};  // r, g, b
        set_full_addr:       full_addr <= (p[0] != 8'h00);
        enable_breakpoints:  bp_arm <= 1'b1;
        disable_breakpoints: bp_arm <= 1'b0;
        default: ;
      endcase
    end
  end

  // any key down in any row
  always_comb begin
    any_key = 1'b0;
    for (int r = 0; r < 8; r++)
      any_key = any_key | (|keyb[r]);
  end

  assign key_pressed = any_key;
  assign reset_req   = keyb[7][1];   // reset key sits in row 7

endmodule

// ==== verilog/breakpoint_unit.sv ====
`timescale 1ns/100ps

module breakpoint_unit #(
  parameter int NUM_BP = 8
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      bp_set,
  input  logic                      bp_clear,
  input  logic                      bp_resume,
  input  logic                      bp_arm,
  input  logic [$clog2(NUM_BP)-1:0] bp_slot,
  input  trs_io_pkg::addr_t         bp_addr,
  input  trs_io_pkg::addr_t         bus_addr,
  input  logic                      bus_rd,
  output logic                      halted,
  output logic [$clog2(NUM_BP)-1:0] halt_slot
);
  import trs_io_pkg::*;

  localparam int SLOT_W = $clog2(NUM_BP);

  addr_t             bp_tab [NUM_BP];   // watched addresses
  logic [NUM_BP-1:0] bp_active;
  logic [NUM_BP-1:0] hit;
  logic [SLOT_W-1:0] hit_slot;
  logic              rd_q;
  logic              rd_rise;

  assign rd_rise = bus_rd && !rd_q;   // new read cycle only

  // lowest matching slot wins
  always_comb begin
    hit_slot = '0;
    for (int i = NUM_BP - 1; i >= 0; i--) begin
      hit[i] = bp_active[i] && (bp_tab[i] == bus_addr);
      if (hit[i])
        hit_slot = SLOT_W'(i);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bp_active <= '0;
      rd_q      <= 1'b0;
      halted    <= 1'b0;
    end else begin
      rd_q <= bus_rd;
      if (bp_set)
        bp_active[bp_slot] <= 1'b1;
      else if (bp_clear)
        bp_active[bp_slot] <= 1'b0;
      if (bp_resume)
        halted <= 1'b0;                        // back to run
      else if (bp_arm && !halted && rd_rise && |hit)
        halted <= 1'b1;                        // stop state
    end
  end

  // table contents and stop slot
  always_ff @(posedge clk) begin
    if (bp_set)
      bp_tab[bp_slot] <= bp_addr;
    if (!rst && !bp_resume && bp_arm && !halted && rd_rise && |hit)
      halt_slot <= hit_slot;
  end

  // executor issues one table operation per cycle
  set_clear_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(bp_set && bp_clear));

endmodule

// ==== verilog/trs_io_ctrl.sv ====
`timescale 1ns/100ps

module trs_io_ctrl #(
  parameter int NUM_BP      = 8,
  parameter int CMD_DEPTH   = 4,
  parameter int REPLY_DEPTH = 2
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      sck,
  input  logic                      cs_n,
  input  logic                      mosi,
  output logic                      miso,
  input  trs_io_pkg::addr_t         bus_addr,
  input  logic                      bus_rd,
  output logic                      halted,
  output logic [$clog2(NUM_BP)-1:0] halt_slot,
  output logic                      key_pressed,
  output logic                      reset_req,
  output trs_io_pkg::rgb_t          screen_rgb,
  output logic                      full_addr
);
  import trs_io_pkg::*;

  logic                      rx_valid;
  byte_t                     rx_byte;
  logic                      cmd_valid;   // framer -> command queue
  cmd_frame_t                cmd_frame;
  logic                      cmd_ready;
  logic                      exe_valid;   // command queue -> executor
  cmd_frame_t                exe_frame;
  logic                      exe_ready;
  logic                      rep_valid;   // executor -> reply queue
  byte_t                     rep_byte;
  logic                      rep_ready;
  logic                      tx_valid;    // reply queue -> spi
  byte_t                     tx_byte;
  logic                      tx_ready;
  logic                      bp_set;
  logic                      bp_clear;
  logic                      bp_resume;
  logic                      bp_arm;
  logic [$clog2(NUM_BP)-1:0] bp_slot;
  addr_t                     bp_addr;

  spi_byte_link u_spi_byte_link (
    .clk, .rst, .sck, .cs_n, .mosi, .miso,
    .rx_valid, .rx_byte, .tx_valid, .tx_byte, .tx_ready
  );

  cmd_framer u_cmd_framer (
    .clk, .rst, .rx_valid, .rx_byte, .cmd_valid, .cmd_frame, .cmd_ready
  );

  frame_queue #(.payload_t(cmd_frame_t), .DEPTH(CMD_DEPTH)) u_cmd_queue (
    .clk, .rst,
    .in_valid(cmd_valid), .in_data(cmd_frame), .in_ready(cmd_ready),
    .out_valid(exe_valid), .out_data(exe_frame), .out_ready(exe_ready)
  );

  cmd_executor #(.NUM_BP(NUM_BP)) u_cmd_executor (
    .clk, .rst, .exe_valid, .exe_frame, .exe_ready,
    .rep_valid, .rep_byte, .rep_ready,
    .bp_set, .bp_clear, .bp_resume, .bp_slot, .bp_addr, .bp_arm,
    .key_pressed, .reset_req, .screen_rgb, .full_addr
  );

  frame_queue #(.payload_t(byte_t), .DEPTH(REPLY_DEPTH)) u_reply_queue (
    .clk, .rst,
    .in_valid(rep_valid), .in_data(rep_byte), .in_ready(rep_ready),
    .out_valid(tx_valid), .out_data(tx_byte), .out_ready(tx_ready)
  );

  breakpoint_unit #(.NUM_BP(NUM_BP)) u_breakpoint_unit (
    .clk, .rst, .bp_set, .bp_clear, .bp_resume, .bp_arm, .bp_slot, .bp_addr,
    .bus_addr, .bus_rd, .halted, .halt_slot
  );

endmodule

// ==== verification/tb_trs_io_tasks.svh ====
task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                     input string what);
  if (actual !== expected) begin
    $display("mismatch at %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
    abort_run("value check failed");
  end
endtask

// spi mode 0, msb first, 8 clk cycles per sck half period
task automatic spi_xfer(input byte_t tx, output byte_t rx);
  int i;
  for (i = 7; i >= 0; i--) begin
    mosi = tx[i];
    repeat (8) @(negedge clk);
    sck   = 1'b1;
    rx[i] = miso;            // master samples on rising sck
    repeat (8) @(negedge clk);
    sck = 1'b0;
  end
endtask

// opcode plus n parameter bytes, miso ignored
task automatic send_cmd(input byte_t op, input int n, input byte_t p0 = 8'h00,
                        input byte_t p1 = 8'h00, input byte_t p2 = 8'h00);
  byte_t unused;
  byte_t p [3];
  int    k;
  p[0] = p0;
  p[1] = p1;
  p[2] = p2;
  spi_xfer(op, unused);
  for (k = 0; k < n; k++)
    spi_xfer(p[k], unused);
endtask

// one-cycle cpu read strobe
task automatic bus_read(input addr_t a);
  bus_addr = a;
  bus_rd   = 1'b1;
  @(negedge clk);
  bus_rd = 1'b0;
  @(negedge clk);
endtask

task automatic test_replies();
  byte_t rx;
  send_cmd(get_cookie, 0);
  repeat (16) @(negedge clk);   // gap before the read exchange
  spi_xfer(8'hff, rx);          // filler byte, not an opcode
  check(rx, 8'haf, "cookie reply");
  send_cmd(get_version, 0);
  repeat (16) @(negedge clk);
  spi_xfer(8'hff, rx);
  check(rx, 8'h03, "version reply");  // major 0, minor 3
endtask

task automatic test_keyboard();
  byte_t row;
  byte_t val;
  row = byte_t'({$random(seed)} % 7);   // rows 0..6 only
  val = byte_t'($random(seed));
  if (val == 8'h00)
    val = 8'h01;
  send_cmd(send_keyb, 2, row, val);
  wait_level(F_KEY, 1'b1, "key_pressed high");
  check(reset_req, 1'b0, "reset_req with a normal key");
  send_cmd(send_keyb, 2, 8'd7, val | 8'h02);   // reset key, row 7 bit 1
  wait_level(F_RESET, 1'b1, "reset_req high");
  send_cmd(send_keyb, 2, row, 8'h00);
  check(key_pressed, 1'b1, "key_pressed while row 7 held");
  send_cmd(send_keyb, 2, 8'd7, 8'h00);
  wait_level(F_KEY, 1'b0, "key_pressed low");
  check(reset_req, 1'b0, "reset_req after release");
endtask

task automatic test_screen_config();
  rgb_t c;
  c = rgb_t'($random(seed));
  send_cmd(set_screen_color, 3, c[23:16], c[15:8], c[7:0]);  // r, g, b
  wait_rgb(c);
  send_cmd(set_full_addr, 1, 8'h01);
  wait_level(F_FULL, 1'b1, "full_addr high");
  send_cmd(set_full_addr, 1, 8'h00);
  wait_level(F_FULL, 1'b0, "full_addr low");
endtask

task automatic test_breakpoint_hit();
  bp_target = addr_t'($random(seed));
  send_cmd(set_breakpoint, 3, 8'd3, bp_target[7:0], bp_target[15:8]);
  send_cmd(enable_breakpoints, 0);
  bus_read(bp_target ^ 16'h0100);       // near miss
  hold_level(F_HALT, 1'b0, "halted on other address");
  bus_read(bp_target);
  wait_level(F_HALT, 1'b1, "halted on breakpoint");
  check(halt_slot, 3, "halt_slot");
  send_cmd(xray_resume, 0);
  wait_level(F_HALT, 1'b0, "halted after resume");
endtask

task automatic test_breakpoint_off();
  send_cmd(disable_breakpoints, 0);
  bus_read(bp_target);
  hold_level(F_HALT, 1'b0, "halted while disarmed");
  send_cmd(enable_breakpoints, 0);
  send_cmd(clear_breakpoint, 1, 8'd3);  // slot 3 inactive again
  bus_read(bp_target);
  hold_level(F_HALT, 1'b0, "halted after clear");
endtask

task automatic test_back_to_back();
  rgb_t cols [5];
  rgb_t prev;
  int   k;
  prev = screen_rgb;
  for (k = 0; k < 5; k++) begin
    cols[k] = rgb_t'($random(seed));
    if (cols[k] == prev)
      cols[k] = ~cols[k];   // every frame must be a visible change
    prev = cols[k];
  end
  rgb_seen.delete();
  rgb_log_on = 1'b1;
  for (k = 0; k < 5; k++)
    send_cmd(set_screen_color, 3, cols[k][23:16], cols[k][15:8], cols[k][7:0]);
  wait_rgb(cols[4]);
  rgb_log_on = 1'b0;
  check(rgb_seen.size(), 5, "number of colour updates");
  for (k = 0; k < 5; k++)
    check(rgb_seen[k], cols[k], "colour order");
endtask

// ==== verification/tb_trs_io_ctrl.sv ====
`timescale 1ns/100ps

module tb_trs_io_ctrl;
  import trs_io_pkg::*;

  localparam int NUM_BP = 8;
  localparam int SLOT_W = $clog2(NUM_BP);

  // selectors for the single-bit outputs polled by the wait loops
  localparam int F_KEY   = 0;
  localparam int F_RESET = 1;
  localparam int F_FULL  = 2;
  localparam int F_HALT  = 3;

  logic              clk;
  logic              rst;
  logic              sck;
  logic              cs_n;
  logic              mosi;
  logic              miso;
  addr_t             bus_addr;
  logic              bus_rd;
  logic              halted;
  logic [SLOT_W-1:0] halt_slot;
  logic              key_pressed;
  logic              reset_req;
  rgb_t              screen_rgb;
  logic              full_addr;

  int   seed;          // $random state
  addr_t bp_target;    // breakpoint address shared by the bp tests
  logic rgb_log_on;    // record colour changes
  rgb_t rgb_last;
  rgb_t rgb_seen [$];

  trs_io_ctrl #(.NUM_BP(NUM_BP), .CMD_DEPTH(4), .REPLY_DEPTH(2)) u_trs_io_ctrl (
    .clk, .rst, .sck, .cs_n, .mosi, .miso, .bus_addr, .bus_rd, .halted, .halt_slot,
    .key_pressed, .reset_req, .screen_rgb, .full_addr
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns
  end

  // colour history, sampled away from the active edge
  always @(negedge clk) begin
    if (rgb_log_on && screen_rgb !== rgb_last)
      rgb_seen.push_back(screen_rgb);
    rgb_last = screen_rgb;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on error");
  endtask

  function automatic logic flag_now(input int sel);
    case (sel)
      F_KEY:   return key_pressed;
      F_RESET: return reset_req;
      F_FULL:  return full_addr;
      default: return halted;
    endcase
  endfunction

  // poll until the output reaches level, bounded
  task automatic wait_level(input int sel, input logic level, input string what);
    int n;
    n = 0;
    while (flag_now(sel) !== level) begin
      if (n == 20)
        abort_run($sformatf("timeout at %0t ns waiting for %s", $time, what));
      else begin
        n++;
        @(negedge clk);
      end
    end
  endtask

  // output must stay put for a few cycles
  task automatic hold_level(input int sel, input logic level, input string what);
    int n;
    for (n = 0; n < 8; n++) begin
      @(negedge clk);
      check(flag_now(sel), level, what);
    end
  endtask

  task automatic wait_rgb(input rgb_t want);
    int n;
    n = 0;
    while (screen_rgb !== want && n < 20) begin
      n++;
      @(negedge clk);
    end
    check(screen_rgb, want, "screen_rgb");  // still wrong after timeout
  endtask

  `include "tb_trs_io_tasks.svh"

  initial begin
    seed       = 32'h2abd3b62;
    rst        = 1'b1;
    sck        = 1'b0;   // mode 0 idle
    cs_n       = 1'b1;
    mosi       = 1'b0;
    bus_addr   = '0;
    bus_rd     = 1'b0;
    bp_target  = '0;
    rgb_log_on = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    check(halted, 1'b0, "halted after reset");
    check(full_addr, 1'b0, "full_addr after reset");
    check(reset_req, 1'b0, "reset_req after reset");
    check(screen_rgb, 24'hffffff, "screen_rgb after reset");  // white
    check(miso, 1'b0, "miso while deselected");
    cs_n = 1'b0;                 // select held for the whole run
    repeat (8) @(negedge clk);   // let cs through the synchronizer
    test_replies();
    test_keyboard();
    test_screen_config();
    test_breakpoint_hit();
    test_breakpoint_off();
    test_back_to_back();
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+verification
verilog/trs_io_pkg.sv
verilog/spi_byte_link.sv
verilog/cmd_framer.sv
verilog/frame_queue.sv
verilog/cmd_executor.sv
verilog/breakpoint_unit.sv
verilog/trs_io_ctrl.sv
verification/tb_trs_io_ctrl.sv

// ==== Makefile ====
TOP  := tb_trs_io_ctrl
SRCS := $(filter %.sv,$(shell cat verilog.f))

.PHONY: all run clean

all: run

obj_dir/V$(TOP): verilog.f $(SRCS) verification/tb_trs_io_tasks.svh
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
